//--- trig_alignment.f
+incdir+logic
logic/trig_alignment_pkg.sv
logic/oversampler.sv
logic/frame_aligner.sv
logic/fat_receiver.sv
logic/trig_alignment.sv
dv/tb_trig_alignment.sv

//--- Makefile
TOP := tb_trig_alignment

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f trig_alignment.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_trig_alignment.sv
`include "trig_alignment_defs.svh"

module tb_trig_alignment;
  timeunit 1ns;
  timeprecision 1ps;
  import trig_alignment_pkg::*;

  localparam int NF = `TA_NUM_FATS;
  localparam int NL = `TA_LINES_PER_FAT;
  localparam int FB = `TA_FRAME_BITS;
  localparam int NP = `TA_PHASES;

  localparam int RESET_CYCLES    = 4;
  localparam int IDLE_CYCLES     = 12;
  localparam int RECOVERY_FRAMES = 40;
  localparam int MASK_FRAMES     = 20;
  localparam int TRACK_FRAMES    = 20;
  localparam int SKEW_FRAMES     = 20;
  localparam int SOF_FRAMES      = 12;
  localparam int FLUSH_CYCLES    = 4;
  localparam int ALL_FRAMES      = RECOVERY_FRAMES + MASK_FRAMES + TRACK_FRAMES +
                                   SKEW_FRAMES + SOF_FRAMES;
  localparam int RUN_CYCLES      = RESET_CYCLES + IDLE_CYCLES + FB * ALL_FRAMES +
                                   FLUSH_CYCLES;
  localparam int CYCLE_LIMIT     = RUN_CYCLES + 200;

  localparam int TRACK_FAT = 3;
  localparam int SKEW_FAT  = 11;
  localparam int SKEW_LINE = 5;
  localparam int SOF_FAT   = 17;

  typedef struct packed {
    int                  due;   // Falling edge at which valid is expected.
    logic [NL*FB-1:0]    sbits;
  } exp_frame_t;

  logic          clock;
  logic          arst_n;
  logic [NF-1:0] sbit_mask;
  fat_samples_t  samples [NF];
  fat_frame_t    frames  [NF];
  fat_status_t   status  [NF];

  logic [31:0]   rng_state;
  phase_sel_t    offset     [NF][NL+1]; // Index NL is the start-of-frame line.
  logic [NL:0]   prev_bits  [NF];
  logic [NL:0]   rec_bits   [NF];       // Bits the oversamplers pick this cycle.
  phase_sel_t    model_sel  [NF];
  logic [NL-1:0] exp_perr   [NF];
  int            frame_pos  [NF];
  bit            delay_sof  [NF];
  int            al_cnt     [NF];
  bit            al_locked  [NF];
  logic [FB-1:0] al_shift   [NF][NL];
  bit            exp_align_err [NF];
  exp_frame_t    exp_q      [NF][$];

  int cycle;
  int clock_count;
  int errors;
  int test_errors;
  int test_count;
  int align_err_seen [NF];
  int skew_perr      [NL];
  bit drive_frames;
  bit random_mask;

  trig_alignment i_trig_alignment (
    .clock     (clock),
    .arst_n    (arst_n),
    .sbit_mask (sbit_mask),
    .samples   (samples),
    .frames    (frames),
    .status    (status)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic report_error(string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(string name);
    test_count++;
    $display("test %0d %s done, %0d errors", test_count, name, test_errors);
    test_errors = 0;
  endtask

  // Compare the outputs after the last rising edge with the model.
  task automatic check_outputs();
    exp_frame_t head;
    for (int f = 0; f < NF; f++) begin
      if (exp_q[f].size() > 0 && exp_q[f][0].due == cycle) begin
        head = exp_q[f].pop_front();
        assert (frames[f].valid)
          else report_error($sformatf("fat %0d expected frame missing", f));
        if (frames[f].valid) begin
          assert (frames[f].sbits == head.sbits)
            else report_error($sformatf("fat %0d sbits %h, expected %h",
                                        f, frames[f].sbits, head.sbits));
        end
      end else begin
        assert (!frames[f].valid)
          else report_error($sformatf("fat %0d valid without a frame", f));
      end
      assert (status[f].alignment_err == exp_align_err[f])
        else report_error($sformatf("fat %0d alignment_err %b, expected %b",
                                    f, status[f].alignment_err, exp_align_err[f]));
      assert (!status[f].sof_phase_err)
        else report_error($sformatf("fat %0d sof_phase_err set", f));
      assert (status[f].phase_err == exp_perr[f])
        else report_error($sformatf("fat %0d phase_err %b, expected %b",
                                    f, status[f].phase_err, exp_perr[f]));
      if (status[f].alignment_err) begin
        align_err_seen[f]++;
      end
      if (f == SKEW_FAT) begin
        for (int l = 0; l < NL; l++) begin
          skew_perr[l] += int'(status[f].phase_err[l]);
        end
      end
    end
  endtask

  // Framing of the bits registered at the previous rising edge.
  task automatic align_step(int f);
    bit         sof;
    exp_frame_t ef;
    sof = rec_bits[f][NL];
    exp_align_err[f] = 1'b0;
    if (al_locked[f] && sof && al_cnt[f] != FB - 1) begin
      exp_align_err[f] = 1'b1; // Marker inside a frame.
    end
    if (al_locked[f] && !sof && al_cnt[f] == FB - 1) begin
      exp_align_err[f] = 1'b1; // Marker missing.
      al_locked[f] = 1'b0;
    end
    al_cnt[f] = sof ? 0 : (al_cnt[f] + 1) % FB;
    if (sof) begin
      al_locked[f] = 1'b1;
    end
    for (int l = 0; l < NL; l++) begin
      al_shift[f][l] = {al_shift[f][l][FB-2:0], rec_bits[f][l]};
    end
    if (al_locked[f] && al_cnt[f] == FB - 1) begin
      ef.due = cycle + 1;
      for (int l = 0; l < NL; l++) begin
        ef.sbits[l*FB +: FB] = sbit_mask[f] ? '0 : al_shift[f][l];
      end
      exp_q[f].push_back(ef);
    end
  endtask

  // New bits for one fat, turned into oversampled lines.
  task automatic drive_fat(int f);
    logic [31:0]   r;
    logic [NL:0]   cur;
    fat_samples_t  fs;
    line_samples_t ls;
    phase_sel_t    sel;
    r = next_random();
    cur = '0;
    if (drive_frames) begin
      cur[NL-1:0] = r[NL-1:0];
      cur[NL] = (frame_pos[f] == 0);
      if (frame_pos[f] == FB - 1) begin
        frame_pos[f] = delay_sof[f] ? FB - 3 : 0; // Late marker adds three bits.
        delay_sof[f] = 1'b0;
      end else begin
        frame_pos[f]++;
      end
    end
    sel = model_sel[f];
    for (int l = 0; l <= NL; l++) begin
      for (int k = 0; k < NP; k++) begin
        ls[k] = (k < offset[f][l]) ? prev_bits[f][l] : cur[l];
      end
      rec_bits[f][l] = ls[sel];
      if (l < NL) begin
        fs.data[l] = ls;
        exp_perr[f][l] = (cur[l] != prev_bits[f][l]) &&
                         (offset[f][l] == sel || offset[f][l] == phase_sel_t'(sel + 1));
      end else begin
        fs.sof = ls;
      end
    end
    if (cur[NL] != prev_bits[f][NL]) begin
      model_sel[f] = phase_sel_t'(offset[f][NL] + 2); // Half a bit from the edge.
    end
    prev_bits[f] = cur;
    samples[f] = fs;
  endtask

  task automatic run_cycle();
    logic [31:0] r;
    @(negedge clock);
    cycle++;
    check_outputs();
    if (random_mask) begin
      r = next_random();
      sbit_mask = r[NF-1:0];
    end else begin
      sbit_mask = '0;
    end
    for (int f = 0; f < NF; f++) begin
      align_step(f);
      drive_fat(f);
    end
  endtask

  initial begin
    int         seen;
    phase_sel_t dut_sel;
    rng_state = 32'h3516_fceb;
    arst_n = 1'b0;
    sbit_mask = '0;
    cycle = 0;
    errors = 0;
    test_errors = 0;
    test_count = 0;
    drive_frames = 1'b0;
    random_mask = 1'b0;
    for (int f = 0; f < NF; f++) begin
      samples[f] = '0;
      prev_bits[f] = '0;
      rec_bits[f] = '0;
      exp_perr[f] = '0;
      model_sel[f] = phase_sel_t'(2);
      frame_pos[f] = 0;
      delay_sof[f] = 1'b0;
      al_cnt[f] = 0;
      al_locked[f] = 1'b0;
      exp_align_err[f] = 1'b0;
      align_err_seen[f] = 0;
      offset[f][0] = phase_sel_t'(next_random() % NP);
      for (int l = 0; l <= NL; l++) begin
        offset[f][l] = offset[f][0];
      end
      for (int l = 0; l < NL; l++) begin
        al_shift[f][l] = '0;
      end
    end

    repeat (RESET_CYCLES) run_cycle();
    arst_n = 1'b1;
    repeat (IDLE_CYCLES) run_cycle();
    finish_test("reset_state");

    drive_frames = 1'b1;
    repeat (RECOVERY_FRAMES * FB) run_cycle();
    finish_test("frame_recovery");

    random_mask = 1'b1;
    repeat (MASK_FRAMES * FB) run_cycle();
    random_mask = 1'b0;
    finish_test("masking");

    // Neighbouring offset keeps the fat on the same side of its sample point.
    seen = align_err_seen[TRACK_FAT];
    for (int l = 0; l <= NL; l++) begin
      offset[TRACK_FAT][l] = offset[TRACK_FAT][l] ^ phase_sel_t'(1);
    end
    repeat (TRACK_FRAMES * FB) run_cycle();
    dut_sel = i_trig_alignment.g_fat[TRACK_FAT].i_fat_receiver.fat_phase_sel;
    assert (dut_sel == phase_sel_t'(offset[TRACK_FAT][NL] + 2))
      else report_error($sformatf("fat %0d selection %0d did not follow the new edge",
                                  TRACK_FAT, dut_sel));
    assert (align_err_seen[TRACK_FAT] == seen)
      else report_error($sformatf("fat %0d alignment error after phase change", TRACK_FAT));
    finish_test("phase_tracking");

    for (int l = 0; l < NL; l++) begin
      skew_perr[l] = 0;
    end
    offset[SKEW_FAT][SKEW_LINE] = model_sel[SKEW_FAT]; // Edge right on the sample.
    repeat (SKEW_FRAMES * FB) run_cycle();
    for (int l = 0; l < NL; l++) begin
      if (l == SKEW_LINE) begin
        assert (skew_perr[l] > 0)
          else report_error($sformatf("fat %0d line %0d never flagged a phase error",
                                      SKEW_FAT, l));
      end else begin
        assert (skew_perr[l] == 0)
          else report_error($sformatf("fat %0d line %0d flagged %0d phase errors",
                                      SKEW_FAT, l, skew_perr[l]));
      end
    end
    offset[SKEW_FAT][SKEW_LINE] = offset[SKEW_FAT][NL];
    finish_test("data_skew");

    seen = align_err_seen[SOF_FAT];
    delay_sof[SOF_FAT] = 1'b1;
    repeat (SOF_FRAMES * FB + FLUSH_CYCLES) run_cycle();
    assert (align_err_seen[SOF_FAT] == seen + 1)
      else report_error($sformatf("fat %0d raised %0d alignment errors for one late marker",
                                  SOF_FAT, align_err_seen[SOF_FAT] - seen));
    finish_test("misplaced_sof");

    $display("%0d tests run, %0d errors", test_count, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog on the clock.
  initial begin
    clock_count = 0;
    while (clock_count <= CYCLE_LIMIT) begin
      @(posedge clock);
      clock_count++;
    end
    $display("Run stopped after %0d cycles without reaching the end of the tests",
             CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- logic/trig_alignment.sv
`include "trig_alignment_defs.svh"

module trig_alignment (
  input  logic                             clock,
  input  logic                             arst_n,
  input  logic [`TA_NUM_FATS-1:0]          sbit_mask, // Set bit zeroes that chip's word.
  input  trig_alignment_pkg::fat_samples_t samples [`TA_NUM_FATS],
  output trig_alignment_pkg::fat_frame_t   frames  [`TA_NUM_FATS],
  output trig_alignment_pkg::fat_status_t  status  [`TA_NUM_FATS]
);

  // One receiver per chip. Each locks to its own start-of-frame line.
  generate
    for (genvar ifat = 0; ifat < `TA_NUM_FATS; ifat++) begin : g_fat
      fat_receiver i_fat_receiver (
        .clock   (clock),
        .arst_n  (arst_n),
        .samples (samples[ifat]),
        .mask    (sbit_mask[ifat]),
        .frame   (frames[ifat]),
        .status  (status[ifat])
      );
    end
  endgenerate

endmodule

//--- logic/fat_receiver.sv
`include "trig_alignment_defs.svh"

module fat_receiver (
  input  logic                             clock,
  input  logic                             arst_n,
  input  trig_alignment_pkg::fat_samples_t samples,
  input  logic                             mask,
  output trig_alignment_pkg::fat_frame_t   frame,
  output trig_alignment_pkg::fat_status_t  status
);
  import trig_alignment_pkg::*;

  phase_sel_t                   fat_phase_sel; // Shared by all lines of the chip.
  logic                         sof_bit;
  logic                         sof_phase_err;
  logic [`TA_LINES_PER_FAT-1:0] data_bits;
  logic [`TA_LINES_PER_FAT-1:0] data_phase_err;
  logic                         alignment_err;

  // Start-of-frame line picks the phase.
  oversampler #(
    .PHASE_SEL_MANUAL (0)
  ) i_sof_oversampler (
    .clock         (clock),
    .arst_n        (arst_n),
    .samples       (samples.sof),
    .phase_sel_in  (phase_sel_t'(0)),
    .phase_sel_out (fat_phase_sel),
    .d             (sof_bit),
    .phase_err     (sof_phase_err)
  );

  generate
    for (genvar iline = 0; iline < `TA_LINES_PER_FAT; iline++) begin : g_line
      oversampler #(
        .PHASE_SEL_MANUAL (1)
      ) i_data_oversampler (
        .clock         (clock),
        .arst_n        (arst_n),
        .samples       (samples.data[iline]),
        .phase_sel_in  (fat_phase_sel),
        .phase_sel_out (),
        .d             (data_bits[iline]),
        .phase_err     (data_phase_err[iline])
      );
    end
  endgenerate

  frame_aligner i_frame_aligner (
    .clock         (clock),
    .arst_n        (arst_n),
    .d             (data_bits),
    .sof           (sof_bit),
    .mask          (mask),
    .frame         (frame),
    .alignment_err (alignment_err)
  );

  assign status.alignment_err = alignment_err;
  assign status.sof_phase_err = sof_phase_err;
  assign status.phase_err     = data_phase_err;

endmodule

//--- logic/frame_aligner.sv
`include "trig_alignment_defs.svh"

module frame_aligner (
  input  logic                           clock,
  input  logic                           arst_n,
  input  logic [`TA_LINES_PER_FAT-1:0]   d,
  input  logic                           sof,
  input  logic                           mask,
  output trig_alignment_pkg::fat_frame_t frame,
  output logic                           alignment_err
);
  import trig_alignment_pkg::*;

  localparam int               CNT_W    = $clog2(`TA_FRAME_BITS);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`TA_FRAME_BITS - 1);

  logic [`TA_FRAME_BITS-1:0] shift_q [`TA_LINES_PER_FAT];

  logic [CNT_W-1:0] cnt_q;    // Position of the previous bit in its frame.
  logic [CNT_W-1:0] cnt_next; // Position of the bit arriving now.
  logic             locked_q;
  logic             locked_next;
  logic             misplaced;
  logic             missing;
  logic             complete;

  fat_frame_t frame_next;
  logic       valid_q;
  logic [`TA_LINES_PER_FAT*`TA_FRAME_BITS-1:0] sbits_q;

  // Frame position tracking.
  always_comb begin
    misplaced   = locked_q && sof && (cnt_q != LAST_BIT);  // Early or late marker.
    missing     = locked_q && !sof && (cnt_q == LAST_BIT); // No marker after the last bit.
    cnt_next    = sof ? '0 : cnt_q + 1'b1;
    locked_next = sof || (locked_q && !missing);
    complete    = locked_next && (cnt_next == LAST_BIT);
  end

  // Word assembled from the stored bits plus the bit arriving now.
  always_comb begin
    frame_next.valid = complete;
    for (int l = 0; l < `TA_LINES_PER_FAT; l++) begin
      frame_next.sbits[l*`TA_FRAME_BITS +: `TA_FRAME_BITS] =
        mask ? '0 : {shift_q[l][`TA_FRAME_BITS-2:0], d[l]};
    end
  end

  // First bit ends up in the MSB.
  always_ff @(posedge clock) begin
    for (int l = 0; l < `TA_LINES_PER_FAT; l++) begin
      shift_q[l] <= {shift_q[l][`TA_FRAME_BITS-2:0], d[l]};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q         <= '0;
      locked_q      <= 1'b0;
      valid_q       <= 1'b0;
      alignment_err <= 1'b0;
    end else begin
      cnt_q         <= cnt_next;
      locked_q      <= locked_next; // Dropped on a missing marker.
      valid_q       <= frame_next.valid;
      alignment_err <= misplaced | missing;
    end
  end

  // Word holds until the next frame.
  always_ff @(posedge clock) begin
    if (complete) begin
      sbits_q <= frame_next.sbits;
    end
  end

  assign frame.valid = valid_q;
  assign frame.sbits = sbits_q;

  // Frames are eight bits long, so two words never follow back to back.
  a_valid_single: assert property (
    @(posedge clock) disable iff (!arst_n) frame.valid |=> !frame.valid
  ) else $error("frame_aligner: valid in consecutive cycles");

  // A word is only released eight bits after the marker that opened it.
  a_valid_after_sof: assert property (
    @(posedge clock) disable iff (!arst_n) frame.valid |-> $past(sof, `TA_FRAME_BITS)
  ) else $error("frame_aligner: valid without a start-of-frame marker");

endmodule

//--- logic/oversampler.sv
`include "trig_alignment_defs.svh"

module oversampler #(
  parameter int PHASE_SEL_MANUAL = 0
) (
  input  logic                              clock,
  input  logic                              arst_n,
  input  trig_alignment_pkg::line_samples_t samples,
  input  trig_alignment_pkg::phase_sel_t    phase_sel_in,
  output trig_alignment_pkg::phase_sel_t    phase_sel_out,
  output logic                              d,
  output logic                              phase_err
);
  import trig_alignment_pkg::*;

  logic          last_sample; // Phase 3 sample of the previous bit.
  line_samples_t edges;       // Bit e set when sample e differs from its neighbour before it.
  phase_sel_t    sel_now;     // Phase used for the bit of this cycle.
  phase_sel_t    sel_check;   // Phase the edges are checked against.
  phase_sel_t    sel_after;
  logic          near_edge;

  // Edge at position 0 crosses the cycle boundary.
  always_comb begin
    edges[0] = samples[0] ^ last_sample;
    for (int e = 1; e < `TA_PHASES; e++) begin
      edges[e] = samples[e] ^ samples[e-1];
    end
  end

  generate
    if (PHASE_SEL_MANUAL != 0) begin : g_manual
      // Phase comes from the start-of-frame line of the same chip.
      assign sel_now   = phase_sel_in;
      assign sel_check = phase_sel_in;
    end else begin : g_auto
      phase_sel_t sel_q;
      phase_sel_t sel_next;

      // Sample half a bit away from the last edge seen.
      always_comb begin
        sel_next = sel_q;
        for (int e = 0; e < `TA_PHASES; e++) begin
          if (edges[e]) begin
            sel_next = phase_sel_t'(e + 2);
          end
        end
      end

      always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
          sel_q <= phase_sel_t'(2); // Mid-bit until the first edge.
        end else begin
          sel_q <= sel_next;
        end
      end

      assign sel_now   = sel_q;
      assign sel_check = sel_next; // Steered phase is checked.

      // A clean start-of-frame line never puts two edges in one bit,
      // so the steered phase always stays clear of them.
      a_auto_no_phase_err: assert property (
        @(posedge clock) disable iff (!arst_n) !phase_err
      ) else $error("oversampler: start-of-frame line has a glitch");
    end
  endgenerate

  assign sel_after     = sel_check + 1'b1;
  assign near_edge     = edges[sel_check] | edges[sel_after];
  assign phase_sel_out = sel_now;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      last_sample <= 1'b0;
      d           <= 1'b0;
      phase_err   <= 1'b0;
    end else begin
      last_sample <= samples[`TA_PHASES-1];
      d           <= samples[sel_now];
      phase_err   <= near_edge; // Sample sits on or just before an edge.
    end
  end

endmodule

//--- logic/trig_alignment_pkg.sv
`include "trig_alignment_defs.svh"

package trig_alignment_pkg;

  // Index of one sample phase within a bit period.
  typedef logic [$clog2(`TA_PHASES)-1:0] phase_sel_t;

  // Bit k holds the sample taken at phase k.
  typedef logic [`TA_PHASES-1:0] line_samples_t;

  // All inputs of one chip for one bit period.
  typedef struct packed {
    line_samples_t                         sof;
    line_samples_t [`TA_LINES_PER_FAT-1:0] data;
  } fat_samples_t;

  // One recovered trigger word.
  // Line l sits in byte l, first received bit in the byte MSB.
  typedef struct packed {
    logic                                          valid;
    logic [`TA_LINES_PER_FAT*`TA_FRAME_BITS-1:0]   sbits;
  } fat_frame_t;

  // Error flags of one chip.
  typedef struct packed {
    logic                         alignment_err;
    logic                         sof_phase_err;
    logic [`TA_LINES_PER_FAT-1:0] phase_err;
  } fat_status_t;

endpackage

//--- logic/trig_alignment_defs.svh
`ifndef TRIG_ALIGNMENT_DEFS_SVH
`define TRIG_ALIGNMENT_DEFS_SVH

// Front-end chips feeding the trigger path.
`define TA_NUM_FATS 24

// Serial data lines per chip.
`define TA_LINES_PER_FAT 8

// Bits carried by each line between two start-of-frame marks.
`define TA_FRAME_BITS 8

// Samples per bit period, taken at 0, 90, 180 and 270 degrees.
`define TA_PHASES 4

`endif
